// ==== src/core_pkg.sv ====
package core_pkg;

  localparam int LANES     = 4;
  localparam int XLEN      = 32;
  localparam int PC_W      = 28;
  localparam int PACKET_W  = 128;
  localparam int REG_NUM_W = 5;
  localparam int NUM_REGS  = 32;
  localparam int IMM_W     = 17;
  localparam int SHAMT_W   = 5;   // Low bits of b used by shifts

  typedef enum logic [3:0] {
    NOP    = 4'd0,
    ADD    = 4'd1,
    SUB    = 4'd2,
    AND    = 4'd3,
    OR     = 4'd4,
    XOR    = 4'd5,
    SLL    = 4'd6,
    SRL    = 4'd7,
    BRANCH = 4'd8   // Lane 0 only
  } op_e;

  typedef struct packed {
    op_e                  op;
    logic                 imm_sel;
    logic [REG_NUM_W-1:0] rd;
    logic [REG_NUM_W-1:0] rs;
    logic [REG_NUM_W-1:0] rt;
    logic [11:0]          zero;   // Must be zero in register form
  } inst_r_t;

  typedef struct packed {
    op_e                    op;
    logic                   imm_sel;
    logic [REG_NUM_W-1:0]   rd;
    logic [REG_NUM_W-1:0]   rs;
    logic signed [IMM_W-1:0] imm;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  typedef struct packed {
    logic                valid;
    logic [PC_W-1:0]     virtpc;
    logic [PACKET_W-1:0] packet;
  } fetch_t;

  typedef struct packed {
    op_e                  op;
    logic                 we;
    logic [REG_NUM_W-1:0] rd;
    logic [XLEN-1:0]      a;
    logic [XLEN-1:0]      b;
  } lane_op_t;

  typedef struct packed {
    logic                       valid;
    logic [PC_W-1:0]            virtpc;
    lane_op_t [LANES-1:0]       lanes;
  } issue_t;

  typedef struct packed {
    logic            taken;
    logic [PC_W-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                             valid;
    logic [PC_W-1:0]                  virtpc;
    logic [LANES-1:0]                 we;
    logic [LANES-1:0][REG_NUM_W-1:0]  rd;
    logic [LANES-1:0][XLEN-1:0]       data;
  } commit_t;

  typedef struct packed {
    logic [LANES-1:0][REG_NUM_W-1:0] rs;
    logic [LANES-1:0][REG_NUM_W-1:0] rt;
  } rf_read_t;

endpackage

// ==== src/lane_alu.sv ====
`timescale 1ns/1ns

module lane_alu (
  input  core_pkg::op_e              op,
  input  logic [core_pkg::XLEN-1:0]  a,
  input  logic [core_pkg::XLEN-1:0]  b,
  output logic [core_pkg::XLEN-1:0]  result
);
  import core_pkg::*;

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (op)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      SLL:     result = a << shamt;
      SRL:     result = a >> shamt;   // Logical
      default: result = '0;           // NOP and branch
    endcase
  end

endmodule

// ==== src/packet_fetch.sv ====
`timescale 1ns/1ns

module packet_fetch (
  input  logic                         clkrst_core_clk,
  input  logic                         rst_n,
  input  core_pkg::redirect_t          redirect,
  input  logic                         take,
  output logic [core_pkg::PC_W-1:0]    f2ic_paddr,
  output logic                         f2ic_valid,
  input  logic [core_pkg::PACKET_W-1:0] ic2f_packet,
  input  logic                         ic2f_ready,
  output core_pkg::fetch_t             fetched
);
  import core_pkg::*;

  logic [PC_W-1:0] pc_q;        // Next packet to request
  logic [PC_W-1:0] paddr_q;
  logic [PC_W-1:0] next_addr;
  logic            req_q;
  logic            drop_q;      // In-flight packet is stale
  fetch_t          buf_q;
  logic            resp, hold, fill, buf_empty_next, start;

  assign resp = req_q & ic2f_ready;
  assign hold = req_q & ~ic2f_ready;
  assign fill = resp & ~drop_q;
  assign buf_empty_next = redirect.taken | (~fill & (~buf_q.valid | take));
  assign start = ~hold & buf_empty_next;
  assign next_addr = redirect.taken ? redirect.target : pc_q;

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= '0;
      paddr_q <= '0;
      req_q   <= 1'b0;
      drop_q  <= 1'b0;
      buf_q   <= '0;
    end else begin
      if (redirect.taken) begin
        buf_q.valid <= 1'b0;           // Flush wrong-path packet
      end else if (fill) begin
        buf_q.valid  <= 1'b1;
        buf_q.virtpc <= paddr_q;
        buf_q.packet <= ic2f_packet;
      end else if (take) begin
        buf_q.valid <= 1'b0;
      end

      if (resp) drop_q <= 1'b0;
      if (redirect.taken && hold) drop_q <= 1'b1;

      if (hold) begin
        if (redirect.taken) pc_q <= redirect.target;   // Request stays put
      end else if (start) begin
        req_q   <= 1'b1;
        paddr_q <= next_addr;
        pc_q    <= next_addr + 1'b1;
      end else begin
        req_q <= 1'b0;
      end
    end
  end

  assign f2ic_paddr = paddr_q;
  assign f2ic_valid = req_q;
  assign fetched    = buf_q;

endmodule

// ==== src/packet_decode.sv ====
`timescale 1ns/1ns

module packet_decode (
  input  logic                                          clkrst_core_clk,
  input  logic                                          rst_n,
  input  core_pkg::fetch_t                              fetched,
  output logic                                          take,
  output core_pkg::rf_read_t                            rf_read,
  input  logic [core_pkg::LANES-1:0][core_pkg::XLEN-1:0] rs_data,
  input  logic [core_pkg::LANES-1:0][core_pkg::XLEN-1:0] rt_data,
  input  core_pkg::redirect_t                           redirect,
  input  core_pkg::commit_t                             committed,
  output core_pkg::issue_t                              issue
);
  import core_pkg::*;

  inst_u               word    [LANES];
  op_e                 op      [LANES];
  logic [XLEN-1:0]     imm_ext [LANES];
  logic [LANES-1:0]    use_rs, use_rt, hit;
  logic [NUM_REGS-1:0] sb_q;             // Pending writes
  logic [NUM_REGS-1:0] set_mask, clr_mask;
  logic                fire;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      word[l] = fetched.packet[l*XLEN +: XLEN];
      case (word[l].r.op)
        ADD, SUB, AND, OR, XOR, SLL, SRL: op[l] = word[l].r.op;
        BRANCH:  op[l] = (l == 0) ? BRANCH : NOP;   // Other lanes cannot branch
        default: op[l] = NOP;
      endcase
      use_rs[l]  = (op[l] != NOP) && (op[l] != BRANCH);
      use_rt[l]  = use_rs[l] && !word[l].r.imm_sel;
      imm_ext[l] = {{(XLEN-IMM_W){word[l].i.imm[IMM_W-1]}}, word[l].i.imm};
      hit[l] = (use_rs[l] && sb_q[word[l].r.rs]) ||
               (use_rt[l] && sb_q[word[l].r.rt]) ||
               ((op[l] != NOP) && sb_q[word[l].r.rd]);
      rf_read.rs[l] = word[l].r.rs;
      rf_read.rt[l] = word[l].r.rt;
    end
  end

  assign fire = fetched.valid && !(|hit) && !redirect.taken;
  assign take = fire;

  always_comb begin
    issue.valid  = fire;
    issue.virtpc = fetched.virtpc;
    set_mask     = '0;
    clr_mask     = '0;
    for (int l = 0; l < LANES; l++) begin
      issue.lanes[l].op = op[l];
      issue.lanes[l].we = (op[l] != NOP);   // Branch writes the link
      issue.lanes[l].rd = word[l].r.rd;
      issue.lanes[l].a  = rs_data[l];
      issue.lanes[l].b  = use_rt[l] ? rt_data[l] : imm_ext[l];
      if (fire && (op[l] != NOP)) set_mask[word[l].r.rd] = 1'b1;
      if (committed.valid && committed.we[l]) clr_mask[committed.rd[l]] = 1'b1;
    end
  end

  // A register being cleared cannot be set in the same cycle, since
  // issue waits for it
  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      sb_q <= '0;
    end else begin
      sb_q <= (sb_q & ~clr_mask) | set_mask;
    end
  end

endmodule

// ==== src/packet_execute.sv ====
`timescale 1ns/1ns

module packet_execute (
  input  logic                 clkrst_core_clk,
  input  logic                 rst_n,
  input  core_pkg::issue_t     issue,
  output core_pkg::redirect_t  redirect,
  output core_pkg::commit_t    result
);
  import core_pkg::*;

  issue_t                     ex_q;
  logic [LANES-1:0][XLEN-1:0] alu_out;
  logic                       is_branch;

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_q <= '0;
    end else begin
      ex_q <= issue;   // Never stalls
    end
  end

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    lane_alu u_alu (
      .op     (ex_q.lanes[l].op),
      .a      (ex_q.lanes[l].a),
      .b      (ex_q.lanes[l].b),
      .result (alu_out[l])
    );
  end

  assign is_branch = (ex_q.lanes[0].op == BRANCH);

  always_comb begin
    redirect.taken  = ex_q.valid && is_branch;
    redirect.target = ex_q.virtpc + ex_q.lanes[0].b[PC_W-1:0];   // Wraps in PC_W
  end

  always_comb begin
    result.valid  = ex_q.valid;
    result.virtpc = ex_q.virtpc;
    for (int l = 0; l < LANES; l++) begin
      result.we[l]   = ex_q.valid && ex_q.lanes[l].we;
      result.rd[l]   = ex_q.lanes[l].rd;
      result.data[l] = alu_out[l];
    end
    if (is_branch) result.data[0] = {ex_q.virtpc, 4'b0000};   // Link as byte address
  end

endmodule

// ==== src/commit_regfile.sv ====
`timescale 1ns/1ns

module commit_regfile (
  input  logic                                          clkrst_core_clk,
  input  logic                                          rst_n,
  input  core_pkg::commit_t                             result,
  input  core_pkg::rf_read_t                            rf_read,
  output logic [core_pkg::LANES-1:0][core_pkg::XLEN-1:0] rs_data,
  output logic [core_pkg::LANES-1:0][core_pkg::XLEN-1:0] rt_data,
  output core_pkg::commit_t                             commit
);
  import core_pkg::*;

  commit_t         wb_q;
  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else begin
      wb_q <= result;
    end
  end

  // Writes go in lane order so the highest lane wins on a shared rd
  always_ff @(posedge clkrst_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wb_q.valid) begin
      for (int l = 0; l < LANES; l++) begin
        if (wb_q.we[l]) regs[wb_q.rd[l]] <= wb_q.data[l];
      end
    end
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      rs_data[l] = regs[rf_read.rs[l]];   // No bypass from the commit record
      rt_data[l] = regs[rf_read.rt[l]];
    end
  end

  assign commit = wb_q;

endmodule

// ==== src/mcpu_core.sv ====
`timescale 1ns/1ns

module mcpu_core (
  input  logic                          clkrst_core_clk,
  input  logic                          rst_n,
  output logic [core_pkg::PC_W-1:0]     f2ic_paddr,
  output logic                          f2ic_valid,
  input  logic [core_pkg::PACKET_W-1:0] ic2f_packet,
  input  logic                          ic2f_ready,
  output core_pkg::commit_t             commit
);
  import core_pkg::*;

  redirect_t                  redirect;
  fetch_t                     fetched;
  logic                       take;
  rf_read_t                   rf_read;
  logic [LANES-1:0][XLEN-1:0] rs_data, rt_data;
  issue_t                     issue;
  commit_t                    result;

  packet_fetch u_fetch (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .redirect        (redirect),
    .take            (take),
    .f2ic_paddr      (f2ic_paddr),
    .f2ic_valid      (f2ic_valid),
    .ic2f_packet     (ic2f_packet),
    .ic2f_ready      (ic2f_ready),
    .fetched         (fetched)
  );

  packet_decode u_decode (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .fetched         (fetched),
    .take            (take),
    .rf_read         (rf_read),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .redirect        (redirect),
    .committed       (commit),   // Clears scoreboard bits
    .issue           (issue)
  );

  packet_execute u_execute (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .issue           (issue),
    .redirect        (redirect),
    .result          (result)
  );

  commit_regfile u_regfile (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .result          (result),
    .rf_read         (rf_read),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .commit          (commit)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);
  localparam int HALF_PERIOD_NS = 20;   // 40 ns period

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

// ==== testbench/core_asserts.sv ====
`timescale 1ns/1ns

module core_asserts (
  input logic                      clkrst_core_clk,
  input logic                      rst_n,
  input logic [core_pkg::PC_W-1:0] f2ic_paddr,
  input logic                      f2ic_valid,
  input logic                      ic2f_ready,
  input logic                      take,
  input core_pkg::redirect_t       redirect,
  input core_pkg::fetch_t          fetched
);
  int fail_count = 0;   // Polled by tb_core

  req_holds: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    f2ic_valid && !ic2f_ready |=> f2ic_valid && $stable(f2ic_paddr))
    else begin
      fail_count++;
      $error("f2ic request dropped or moved before ic2f_ready");
    end

  idle_in_reset: assert property (@(posedge clkrst_core_clk) !rst_n |-> !f2ic_valid)
    else begin
      fail_count++;
      $error("f2ic_valid high in reset");
    end

  buf_holds: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    fetched.valid && !take && !redirect.taken |=>
      fetched.valid && $stable(fetched.virtpc) && $stable(fetched.packet))
    else begin
      fail_count++;
      $error("Fetch buffer changed while not taken");
    end

endmodule

bind packet_fetch core_asserts u_fetch_asserts (
  .clkrst_core_clk (clkrst_core_clk),
  .rst_n           (rst_n),
  .f2ic_paddr      (f2ic_paddr),
  .f2ic_valid      (f2ic_valid),
  .ic2f_ready      (ic2f_ready),
  .take            (take),
  .redirect        (redirect),
  .fetched         (fetched)
);

// ==== testbench/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

logic [PACKET_W-1:0]             pkt_mem    [MEM_DEPTH];
logic [XLEN-1:0]                 model_regs [NUM_REGS];
logic [PC_W-1:0]                 model_pc;
logic [PC_W-1:0]                 exp_virtpc;   // Expected record of the next commit
logic [LANES-1:0]                exp_we;
logic [LANES-1:0][REG_NUM_W-1:0] exp_rd;
logic [LANES-1:0][XLEN-1:0]      exp_data;

function automatic logic [XLEN-1:0] reg_form(input logic [3:0] op,
                                             input logic [4:0] rd, rs, rt);
  return {op, 1'b0, rd, rs, rt, 12'h000};
endfunction

function automatic logic [XLEN-1:0] imm_form(input logic [3:0] op, input logic [4:0] rd, rs,
                                             input logic [16:0] imm);
  return {op, 1'b1, rd, rs, imm};
endfunction

function automatic logic [XLEN-1:0] random_inst(input int lane);
  logic [3:0] op;
  op = ($urandom % 8 != 0) ? 4'(1 + $urandom % 7) : 4'(8 + $urandom % 8);
  if (lane == 0 && op == BRANCH) op = NOP;   // Lane 0 branches are placed separately
  if ($urandom % 2 == 0) return reg_form(op, 5'($urandom), 5'($urandom), 5'($urandom));
  return imm_form(op, 5'($urandom), 5'($urandom), 17'($urandom));
endfunction

task automatic init_model();
  for (int p = 0; p < MEM_DEPTH; p++) begin
    for (int l = 0; l < LANES; l++) begin
      pkt_mem[p][l*XLEN +: XLEN] = random_inst(l);
    end
    if ($urandom % 6 == 0)   // Forward branch that stays inside the table
      pkt_mem[p][XLEN-1:0] = imm_form(BRANCH, 5'($urandom), 5'd0, 17'(2 + $urandom % 10));
  end
  // Each of the first packets reads what the one before wrote
  pkt_mem[0] = {imm_form(XOR, 5'd4, 5'd0, 17'h0f0f0), imm_form(ADD, 5'd3, 5'd0, 17'd7),
                imm_form(OR, 5'd2, 5'd0, 17'h1fffd), imm_form(ADD, 5'd1, 5'd0, 17'h01234)};
  pkt_mem[1] = {imm_form(SRL, 5'd8, 5'd2, 17'd4), reg_form(SLL, 5'd7, 5'd1, 5'd3),
                reg_form(SUB, 5'd6, 5'd1, 5'd3), reg_form(ADD, 5'd5, 5'd1, 5'd2)};
  pkt_mem[2] = {imm_form(XOR, 5'd9, 5'd6, 17'h00055), reg_form(AND, 5'd10, 5'd2, 5'd4),
                reg_form(SUB, 5'd9, 5'd5, 5'd3), imm_form(ADD, 5'd9, 5'd1, 17'd1)};   // r9 x3
  pkt_mem[3] = {imm_form(SLL, 5'd12, 5'd9, 17'd12), reg_form(SRL, 5'd11, 5'd2, 5'd3),
                reg_form(OR, 5'd13, 5'd9, 5'd10), reg_form(AND, 5'd14, 5'd9, 5'd4)};
  pkt_mem[4][XLEN-1:0] = imm_form(BRANCH, 5'd15, 5'd0, 17'd3);   // Skips packets 5 and 6
  pkt_mem[7][XLEN-1:0] = imm_form(ADD, 5'd16, 5'd15, 17'd1);     // Reads the link
  model_pc = '0;
  for (int r = 0; r < NUM_REGS; r++) begin
    model_regs[r] = '0;
  end
endtask

function automatic logic [XLEN-1:0] alu_ref(input logic [3:0] op, input logic [XLEN-1:0] a, b);
  case (op)
    ADD:     return a + b;
    SUB:     return a - b;
    AND:     return a & b;
    OR:      return a | b;
    XOR:     return a ^ b;
    SLL:     return a << b[4:0];
    SRL:     return a >> b[4:0];
    default: return '0;
  endcase
endfunction

// Runs the packet at model_pc and leaves its record in the exp_ signals
task automatic step_model();
  logic [PACKET_W-1:0] pkt;
  logic [XLEN-1:0]     w, b, imm_ext;
  logic [PC_W-1:0]     next_pc;
  pkt        = pkt_mem[model_pc[MEM_AW-1:0]];
  next_pc    = model_pc + 1'b1;
  exp_virtpc = model_pc;
  for (int l = 0; l < LANES; l++) begin
    w          = pkt[l*XLEN +: XLEN];
    imm_ext    = {{(XLEN-IMM_W){w[16]}}, w[16:0]};
    b          = w[27] ? imm_ext : model_regs[w[16:12]];
    exp_rd[l]  = w[26:22];
    exp_we[l]  = (w[31:28] >= ADD && w[31:28] <= SRL) || (l == 0 && w[31:28] == BRANCH);
    exp_data[l] = alu_ref(w[31:28], model_regs[w[21:17]], b);
    if (l == 0 && w[31:28] == BRANCH) begin
      exp_data[l] = {model_pc, 4'b0000};
      next_pc     = model_pc + imm_ext[PC_W-1:0];
    end
  end
  for (int l = 0; l < LANES; l++) begin
    if (exp_we[l]) model_regs[exp_rd[l]] = exp_data[l];   // Highest lane last
  end
  model_pc = next_pc;
endtask

`endif

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;
  import core_pkg::*;

  localparam int          MEM_AW            = 6;
  localparam int          MEM_DEPTH         = 1 << MEM_AW;   // 64 packets
  localparam int          NUM_COMMITS       = 400;
  localparam int          CYCLES_PER_COMMIT = 24;
  localparam int          TIMEOUT_CYCLES    = NUM_COMMITS * CYCLES_PER_COMMIT;
  localparam int          RESET_CYCLES      = 5;
  localparam logic [31:0] SEED              = 32'h46b9;

  logic                clkrst_core_clk;
  logic                rst_n;
  logic [PC_W-1:0]     f2ic_paddr;
  logic                f2ic_valid;
  logic [PACKET_W-1:0] ic2f_packet;
  logic                ic2f_ready;
  commit_t             commit;

  int   commit_count = 0;
  int   cycle_count  = 0;
  int   wait_left    = 0;
  logic busy         = 1'b0;
  logic first_req    = 1'b1;

  `include "core_model.svh"

  tb_clock u_clock (
    .clk (clkrst_core_clk)
  );

  mcpu_core mcpu_core_i (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .f2ic_paddr      (f2ic_paddr),
    .f2ic_valid      (f2ic_valid),
    .ic2f_packet     (ic2f_packet),
    .ic2f_ready      (ic2f_ready),
    .commit          (commit)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_commit();
    step_model();
    assert (commit.virtpc == exp_virtpc) else
      abort_run($sformatf("[ERROR] commit.virtpc got %h expected %h", commit.virtpc, exp_virtpc));
    for (int l = 0; l < LANES; l++) begin
      assert (commit.we[l] == exp_we[l]) else
        abort_run($sformatf("[ERROR] commit.we[%0d] got %h expected %h at virtpc %h",
                            l, commit.we[l], exp_we[l], exp_virtpc));
      if (exp_we[l]) begin
        assert (commit.rd[l] == exp_rd[l]) else
          abort_run($sformatf("[ERROR] commit.rd[%0d] got %h expected %h at virtpc %h",
                              l, commit.rd[l], exp_rd[l], exp_virtpc));
        assert (commit.data[l] == exp_data[l]) else
          abort_run($sformatf("[ERROR] commit.data[%0d] got %h expected %h at virtpc %h",
                              l, commit.data[l], exp_data[l], exp_virtpc));
      end
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    ic2f_ready  = 1'b0;
    ic2f_packet = '0;
    void'($urandom(SEED));
    init_model();
    repeat (RESET_CYCLES) @(posedge clkrst_core_clk);
    @(negedge clkrst_core_clk);
    rst_n = 1'b1;
    wait (commit_count == NUM_COMMITS);
    @(negedge clkrst_core_clk);
    if (mcpu_core_i.u_fetch.u_fetch_asserts.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("A bound assertion on the fetch strobes failed");
    end
  end

  // Instruction cache with 0 to 3 cycles of latency per request
  always @(negedge clkrst_core_clk) begin
    ic2f_ready = 1'b0;
    if (!rst_n) begin
      busy = 1'b0;
    end else if (f2ic_valid) begin
      if (first_req) begin
        assert (f2ic_paddr == '0) else
          abort_run($sformatf("[ERROR] f2ic_paddr got %h expected %h on the first request",
                              f2ic_paddr, 28'h0));
        first_req = 1'b0;
      end
      if (!busy) begin
        busy      = 1'b1;
        wait_left = int'($urandom % 4);
      end
      if (wait_left == 0) begin
        ic2f_packet = pkt_mem[f2ic_paddr[MEM_AW-1:0]];
        ic2f_ready  = 1'b1;
        busy        = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

  // Reset checks, commit checks and the cycle limit
  always @(negedge clkrst_core_clk) begin
    if (!rst_n) begin
      assert (!f2ic_valid) else
        abort_run($sformatf("[ERROR] f2ic_valid got %h expected %h in reset", f2ic_valid, 1'b0));
      assert (!commit.valid) else
        abort_run($sformatf("[ERROR] commit.valid got %h expected %h in reset",
                            commit.valid, 1'b0));
    end else begin
      cycle_count++;
      assert (cycle_count < TIMEOUT_CYCLES) else
        abort_run($sformatf("Timeout: commits stopped after %0d of %0d packets",
                            commit_count, NUM_COMMITS));
      assert (mcpu_core_i.u_fetch.u_fetch_asserts.fail_count == 0) else
        abort_run("A bound assertion on the fetch strobes failed");
      if (commit.valid && commit_count < NUM_COMMITS) begin
        check_commit();
        commit_count++;
      end
    end
  end

endmodule

// ==== filelist.f ====
+incdir+testbench
src/core_pkg.sv
src/lane_alu.sv
src/packet_fetch.sv
src/packet_decode.sv
src/packet_execute.sv
src/commit_regfile.sv
src/mcpu_core.sv
testbench/tb_clock.sv
testbench/core_asserts.sv
testbench/tb_core.sv

// ==== Makefile ====
TOP := tb_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
